// ==== design/lc3b_pkg.sv ====
package lc3b_pkg;

	// Data and address width of the core
	typedef logic [15:0] lc3b_word;

	typedef logic [2:0] lc3b_reg;

	// Widths of the multi-bit control word fields
	localparam int alumux2_sel_w = 2;
	localparam int nzp_w = 3;

	// The opcode field, bits 15 to 12 of the instruction word
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	// Sequencer states, one instruction in flight at a time
	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_memory,
		st_writeback
	} lc3b_state;

endpackage : lc3b_pkg

// ==== design/lc3b_ctrl_if.sv ====
`timescale 1ns/1ps

interface lc3b_ctrl_if;
	import lc3b_pkg::*;

	logic alumux1_sel;
	logic [alumux2_sel_w-1:0] alumux2_sel;
	lc3b_aluop alu_ctrl;
	logic read;
	logic write;
	logic load_regfile;
	logic load_cc;
	logic jump;
	logic branch;
	lc3b_reg dest;
	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_word offset;
	logic [nzp_w-1:0] nzp;

	modport dec (
		output alumux1_sel, alumux2_sel, alu_ctrl,
		output read, write, load_regfile, load_cc, jump, branch,
		output dest, sr1, sr2, offset, nzp
	);

	// Operand selection and register addressing
	modport exe (
		input alumux1_sel, alumux2_sel, alu_ctrl,
		input dest, sr1, sr2, offset
	);

	// Bus, writeback and PC control
	modport res (
		input read, write, load_regfile, load_cc, jump, branch, nzp
	);

endinterface : lc3b_ctrl_if

// ==== design/lc3b_decode.sv ====
`timescale 1ns/1ps

module lc3b_decode (
	input  logic               clk,
	input  logic               arst_n,
	input  lc3b_pkg::lc3b_word ir,
	input  logic               decode_en,
	lc3b_ctrl_if.dec           ctrl
);
	import lc3b_pkg::*;

	lc3b_opcode opcode;
	logic nxt_alumux1_sel;
	logic [alumux2_sel_w-1:0] nxt_alumux2_sel;
	lc3b_aluop nxt_alu_ctrl;
	logic nxt_read;
	logic nxt_write;
	logic nxt_load_regfile;
	logic nxt_load_cc;
	logic nxt_jump;
	logic nxt_branch;
	lc3b_reg nxt_sr2;
	lc3b_word nxt_offset;

	assign opcode = lc3b_opcode'(ir[15:12]);

	// Anything not listed below falls through as a no-op
	always_comb begin
		nxt_alumux1_sel = 1'b0;
		nxt_alumux2_sel = 2'b00;
		nxt_alu_ctrl = alu_pass;
		nxt_read = 1'b0;
		nxt_write = 1'b0;
		nxt_load_regfile = 1'b0;
		nxt_load_cc = 1'b0;
		nxt_jump = 1'b0;
		nxt_branch = 1'b0;
		nxt_sr2 = ir[2:0];
		nxt_offset = {{11{ir[4]}}, ir[4:0]};
		case (opcode)
			op_add, op_and: begin
				nxt_alumux2_sel = ir[5] ? 2'b11 : 2'b00;
				nxt_alu_ctrl = (opcode == op_add) ? alu_add : alu_and;
				nxt_load_regfile = 1'b1;
				nxt_load_cc = 1'b1;
			end
			op_not: begin
				nxt_alu_ctrl = alu_not;
				nxt_load_regfile = 1'b1;
				nxt_load_cc = 1'b1;
			end
			op_shf: begin
				nxt_alumux2_sel = 2'b11;
				nxt_offset = {12'h000, ir[3:0]};
				if (!ir[4])
					nxt_alu_ctrl = alu_sll;
				else if (!ir[5])
					nxt_alu_ctrl = alu_srl;
				else
					nxt_alu_ctrl = alu_sra;
				nxt_load_regfile = 1'b1;
				nxt_load_cc = 1'b1;
			end
			op_ldr, op_str: begin
				nxt_alumux2_sel = 2'b01;
				nxt_alu_ctrl = alu_add;
				nxt_offset = {{10{ir[5]}}, ir[5:0]};
				nxt_read = (opcode == op_ldr);
				nxt_write = (opcode == op_str);
				nxt_load_regfile = (opcode == op_ldr);
				nxt_load_cc = (opcode == op_ldr);
				// Store source sits in the destination field
				nxt_sr2 = ir[11:9];
			end
			op_lea, op_br: begin
				nxt_alumux1_sel = 1'b1;
				nxt_alumux2_sel = 2'b10;
				nxt_alu_ctrl = alu_add;
				nxt_offset = {{7{ir[8]}}, ir[8:0]};
				nxt_load_regfile = (opcode == op_lea);
				nxt_load_cc = (opcode == op_lea);
				nxt_branch = (opcode == op_br);
			end
			op_jmp: begin
				nxt_jump = 1'b1;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl.alumux1_sel <= 1'b0;
			ctrl.alumux2_sel <= '0;
			ctrl.alu_ctrl <= alu_pass;
			ctrl.read <= 1'b0;
			ctrl.write <= 1'b0;
			ctrl.load_regfile <= 1'b0;
			ctrl.load_cc <= 1'b0;
			ctrl.jump <= 1'b0;
			ctrl.branch <= 1'b0;
			ctrl.dest <= '0;
			ctrl.sr1 <= '0;
			ctrl.sr2 <= '0;
			ctrl.offset <= '0;
			ctrl.nzp <= '0;
		end else if (decode_en) begin
			ctrl.alumux1_sel <= nxt_alumux1_sel;
			ctrl.alumux2_sel <= nxt_alumux2_sel;
			ctrl.alu_ctrl <= nxt_alu_ctrl;
			ctrl.read <= nxt_read;
			ctrl.write <= nxt_write;
			ctrl.load_regfile <= nxt_load_regfile;
			ctrl.load_cc <= nxt_load_cc;
			ctrl.jump <= nxt_jump;
			ctrl.branch <= nxt_branch;
			ctrl.dest <= ir[11:9];
			ctrl.sr1 <= ir[8:6];
			ctrl.sr2 <= nxt_sr2;
			ctrl.offset <= nxt_offset;
			ctrl.nzp <= ir[11:9];
		end
	end

endmodule : lc3b_decode

// ==== design/lc3b_execute.sv ====
`timescale 1ns/1ps

module lc3b_execute (
	input  logic               clk,
	input  logic               arst_n,
	lc3b_ctrl_if.exe           ctrl,
	input  lc3b_pkg::lc3b_word pc,
	input  logic               reg_we,
	input  lc3b_pkg::lc3b_word reg_wdata,
	output lc3b_pkg::lc3b_word alu_out,
	output lc3b_pkg::lc3b_word store_data
);
	import lc3b_pkg::*;

	lc3b_word regs [8];
	lc3b_word sr1_data;
	lc3b_word sr2_data;
	lc3b_word opa;
	lc3b_word opb;
	logic [3:0] shamt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_we) begin
			regs[ctrl.dest] <= reg_wdata;
		end
	end

	assign sr1_data = regs[ctrl.sr1];
	assign sr2_data = regs[ctrl.sr2];

	assign store_data = sr2_data;

	// PC is already past the current instruction when it is used here
	assign opa = ctrl.alumux1_sel ? pc : sr1_data;

	always_comb begin
		case (ctrl.alumux2_sel)
			2'b00: opb = sr2_data;
			2'b01: opb = {{9{ctrl.offset[5]}}, ctrl.offset[5:0], 1'b0};
			2'b10: opb = {{6{ctrl.offset[8]}}, ctrl.offset[8:0], 1'b0};
			default: opb = ctrl.offset;
		endcase
	end

	assign shamt = opb[3:0];

	always_comb begin
		case (ctrl.alu_ctrl)
			alu_add: alu_out = opa + opb;
			alu_and: alu_out = opa & opb;
			alu_not: alu_out = ~opa;
			alu_sll: alu_out = opa << shamt;
			alu_srl: alu_out = opa >> shamt;
			// Arithmetic shift keeps the sign bit
			alu_sra: alu_out = lc3b_word'($signed(opa) >>> shamt);
			default: alu_out = opa;
		endcase
	end

endmodule : lc3b_execute

// ==== design/lc3b_result.sv ====
`timescale 1ns/1ps

module lc3b_result #(
	parameter lc3b_pkg::lc3b_word reset_pc = '0
) (
	input  logic               clk,
	input  logic               arst_n,
	lc3b_ctrl_if.res           ctrl,
	input  lc3b_pkg::lc3b_word alu_out,
	input  lc3b_pkg::lc3b_word store_data,
	output lc3b_pkg::lc3b_word ir,
	output lc3b_pkg::lc3b_word pc,
	output logic               decode_en,
	output logic               reg_we,
	output lc3b_pkg::lc3b_word reg_wdata,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic               wb_we,
	output lc3b_pkg::lc3b_word wb_adr,
	output lc3b_pkg::lc3b_word wb_dat_w,
	output logic [1:0]         wb_sel,
	input  lc3b_pkg::lc3b_word wb_dat_r,
	input  logic               wb_ack
);
	import lc3b_pkg::*;

	lc3b_state state;
	lc3b_word mdr;
	lc3b_word pc_next;
	logic [nzp_w-1:0] cc;
	logic [nzp_w-1:0] cc_next;

	// Only whole words move over the bus
	assign wb_sel = 2'b11;

	assign decode_en = (state == st_decode);
	assign reg_we = (state == st_writeback) && ctrl.load_regfile;
	assign reg_wdata = ctrl.read ? mdr : alu_out;

	always_comb begin
		if (reg_wdata[15])
			cc_next = 3'b100;
		else if (reg_wdata == '0)
			cc_next = 3'b010;
		else
			cc_next = 3'b001;
	end

	always_comb begin
		pc_next = pc;
		if (ctrl.jump || (ctrl.branch && |(ctrl.nzp & cc)))
			pc_next = alu_out;
	end

	always_ff @(posedge clk) begin
		if (state == st_fetch && wb_cyc && wb_ack)
			ir <= wb_dat_r;
		if (state == st_memory && wb_ack)
			mdr <= wb_dat_r;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_fetch;
			pc <= reset_pc;
			cc <= 3'b010;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
			wb_adr <= '0;
			wb_dat_w <= '0;
		end else begin
			case (state)
				st_fetch: begin
					// Right after reset the fetch cycle still has to be opened
					if (!wb_cyc) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= 1'b0;
						wb_adr <= pc;
					end else if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						pc <= pc + 16'd2;
						state <= st_decode;
					end
				end
				st_decode: state <= st_execute;
				st_execute: begin
					if (ctrl.read || ctrl.write) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= ctrl.write;
						wb_adr <= alu_out;
						wb_dat_w <= store_data;
						state <= st_memory;
					end else begin
						state <= st_writeback;
					end
				end
				st_memory: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
						state <= st_writeback;
					end
				end
				st_writeback: begin
					if (ctrl.load_cc)
						cc <= cc_next;
					pc <= pc_next;
					// Next fetch starts straight away at the new PC
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
					wb_we <= 1'b0;
					wb_adr <= pc_next;
					state <= st_fetch;
				end
				default: state <= st_fetch;
			endcase
		end
	end

endmodule : lc3b_result

// ==== design/lc3b_core.sv ====
`timescale 1ns/1ps

module lc3b_core #(
	parameter lc3b_pkg::lc3b_word reset_pc = '0
) (
	input  logic               clk,
	input  logic               arst_n,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic               wb_we,
	output lc3b_pkg::lc3b_word wb_adr,
	output lc3b_pkg::lc3b_word wb_dat_w,
	output logic [1:0]         wb_sel,
	input  lc3b_pkg::lc3b_word wb_dat_r,
	input  logic               wb_ack
);
	import lc3b_pkg::*;

	lc3b_word ir;
	lc3b_word pc;
	logic decode_en;
	logic reg_we;
	lc3b_word reg_wdata;
	lc3b_word alu_out;
	lc3b_word store_data;

	lc3b_ctrl_if ctrl_if ();

	lc3b_decode u_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.ir        (ir),
		.decode_en (decode_en),
		.ctrl      (ctrl_if.dec)
	);

	lc3b_execute u_execute (
		.clk        (clk),
		.arst_n     (arst_n),
		.ctrl       (ctrl_if.exe),
		.pc         (pc),
		.reg_we     (reg_we),
		.reg_wdata  (reg_wdata),
		.alu_out    (alu_out),
		.store_data (store_data)
	);

	lc3b_result #(
		.reset_pc (reset_pc)
	) u_result (
		.clk        (clk),
		.arst_n     (arst_n),
		.ctrl       (ctrl_if.res),
		.alu_out    (alu_out),
		.store_data (store_data),
		.ir         (ir),
		.pc         (pc),
		.decode_en  (decode_en),
		.reg_we     (reg_we),
		.reg_wdata  (reg_wdata),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_sel     (wb_sel),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack)
	);

endmodule : lc3b_core

// ==== verification/lc3b_properties.sv ====
`timescale 1ns/1ps

module lc3b_properties (
	input logic               clk,
	input logic               arst_n,
	input logic               wb_cyc,
	input logic               wb_stb,
	input logic               wb_we,
	input lc3b_pkg::lc3b_word wb_adr,
	input lc3b_pkg::lc3b_word wb_dat_w,
	input logic               wb_ack
);

	stb_inside_cyc: assert property (@(posedge clk) disable iff (!arst_n)
		wb_stb |-> wb_cyc)
		else $error("Wishbone stb is high while cyc is low");

	// A waiting master keeps the whole request steady
	request_held: assert property (@(posedge clk) disable iff (!arst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
		else $error("Wishbone request changed before ack");

	cyc_ends_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
		wb_cyc && wb_ack |=> !wb_cyc)
		else $error("Wishbone cyc still high the cycle after ack");

	no_cyc_in_reset: assert property (@(posedge clk)
		!arst_n |-> !wb_cyc)
		else $error("Wishbone cyc is high during reset");

endmodule : lc3b_properties

bind lc3b_core lc3b_properties u_properties (
	.clk      (clk),
	.arst_n   (arst_n),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_we    (wb_we),
	.wb_adr   (wb_adr),
	.wb_dat_w (wb_dat_w),
	.wb_ack   (wb_ack)
);

// ==== verification/lc3b_tb.sv ====
`timescale 1ns/1ps

module lc3b_tb;
	import lc3b_pkg::*;

	localparam lc3b_word reset_pc = 16'h0040;
	localparam int n_prog = 39;
	localparam int n_data = 2;
	localparam int n_store = 13;
	localparam int n_skip = 5;
	localparam int max_cycles = n_prog * 40 + 8;

	// Each entry holds an address in the upper half and a word in the lower half
	localparam logic [31:0] prog [n_prog] = '{
		32'h0040_EC5F, 32'h0042_7D80, 32'h0044_6381, 32'h0046_6582,
		32'h0048_1642, 32'h004A_7784, 32'h004C_5842, 32'h004E_7985,
		32'h0050_187D, 32'h0052_7986, 32'h0054_58B0, 32'h0056_7987,
		32'h0058_9A7F, 32'h005A_7B88, 32'h005C_D884, 32'h005E_7989,
		32'h0060_D89F, 32'h0062_798A, 32'h0064_D8B4, 32'h0066_798B,
		32'h0068_D8B0, 32'h006A_798C, 32'h006C_DA4F, 32'h006E_0A01,
		32'h0070_7B8D, 32'h0072_0401, 32'h0074_7780, 32'h0076_9B7F,
		32'h0078_0601, 32'h007A_7B8E, 32'h007C_0802, 32'h007E_7780,
		32'h0080_7780, 32'h0082_EE03, 32'h0084_C1C0, 32'h0086_7780,
		32'h0088_7780, 32'h008A_7F8F, 32'h008C_0FFF
	};
	localparam logic [31:0] data_init [n_data] = '{32'h0102_1234, 32'h0104_8F0F};
	localparam logic [31:0] exp_store [n_store] = '{
		32'h0100_0100, 32'h0108_A143, 32'h010A_0204, 32'h010C_1231,
		32'h010E_8F00, 32'h0110_EDCB, 32'h0112_F0F0, 32'h0114_0001,
		32'h0116_F8F0, 32'h0118_8F0F, 32'h011A_0000, 32'h011C_FFFF,
		32'h011E_008A
	};
	// Fetches from here mean a branch or jump went the wrong way
	localparam lc3b_word skip_adr [n_skip] = '{
		16'h0074, 16'h007E, 16'h0080, 16'h0086, 16'h0088
	};

	logic clk;
	logic arst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	lc3b_word wb_adr;
	lc3b_word wb_dat_w;
	logic [1:0] wb_sel;
	lc3b_word wb_dat_r;
	logic wb_ack;

	lc3b_word mem [256];
	int store_idx;
	int cycles;
	int wait_cnt;
	logic pending;
	logic first_seen;
	logic done;

	lc3b_core #(
		.reset_pc (reset_pc)
	) u_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_sel   (wb_sel),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	task automatic report_error(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Called at the edge where the core samples ack
	task automatic complete_transfer();
		lc3b_word adr;
		adr = wb_adr;
		assert (adr[15:9] == '0)
			else report_error($sformatf("access outside the memory model at %h", adr));
		assert (wb_sel == 2'b11) else report_error("byte selects are not both set");
		if (wb_we) begin
			assert (first_seen) else report_error("write before the first fetch");
			assert (store_idx < n_store) else report_error("write after the last expected store");
			assert (adr == exp_store[store_idx][31:16])
				else report_error($sformatf("store %0d address %h, expected %h",
					store_idx, adr, exp_store[store_idx][31:16]));
			assert (wb_dat_w == exp_store[store_idx][15:0])
				else report_error($sformatf("store %0d data %h, expected %h",
					store_idx, wb_dat_w, exp_store[store_idx][15:0]));
			mem[adr[8:1]] = wb_dat_w;
			store_idx++;
			if (store_idx == n_store)
				done = 1'b1;
		end else begin
			if (!first_seen) begin
				assert (adr == reset_pc)
					else report_error($sformatf("first fetch at %h, expected %h", adr, reset_pc));
				first_seen = 1'b1;
			end
			for (int k = 0; k < n_skip; k++) begin
				assert (adr != skip_adr[k])
					else report_error($sformatf("fetch from skipped address %h", adr));
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Wishbone slave with 0 to 3 wait cycles per transfer
	initial begin
		void'($urandom(3));
		forever begin
			@(posedge clk);
			if (wb_ack) begin
				complete_transfer();
				#1 wb_ack = 1'b0;
			end else if (arst_n && wb_cyc && wb_stb) begin
				if (!pending) begin
					pending = 1'b1;
					wait_cnt = int'($urandom_range(3, 0));
				end
				if (wait_cnt == 0) begin
					pending = 1'b0;
					#1;
					wb_dat_r = mem[wb_adr[8:1]];
					wb_ack = 1'b1;
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	initial begin
		arst_n = 1'b0;
		wb_ack = 1'b0;
		wb_dat_r = '0;
		store_idx = 0;
		cycles = 0;
		wait_cnt = 0;
		pending = 1'b0;
		first_seen = 1'b0;
		done = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 16'h5A00 ^ (16'(i) * 16'h0107);
		end
		for (int k = 0; k < n_prog; k++) begin
			mem[prog[k][24:17]] = prog[k][15:0];
		end
		for (int k = 0; k < n_data; k++) begin
			mem[data_init[k][24:17]] = data_init[k][15:0];
		end
		repeat (8) @(posedge clk);
		#1 arst_n = 1'b1;
		while (!done) begin
			@(posedge clk);
			cycles++;
			assert (cycles < max_cycles)
				else report_error("timeout, the last expected store never came");
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule : lc3b_tb

// ==== project.f ====
design/lc3b_pkg.sv
design/lc3b_ctrl_if.sv
design/lc3b_decode.sv
design/lc3b_execute.sv
design/lc3b_result.sv
design/lc3b_core.sv
verification/lc3b_properties.sv
verification/lc3b_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the LC-3b core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f project.f --top-module lc3b_tb -o lc3b_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/lc3b_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1
